/* sim.f */
hdl/rv_isa_pkg.sv
hdl/core_cfg_pkg.sv
hdl/mem_req_if.sv
hdl/alu.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/apb_requester.sv
hdl/core_ctrl.sv
hdl/rv_core_top.sv
tb/tb_rv_core.sv

/* tb/tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core import rv_isa_pkg::*, core_cfg_pkg::*; ();

  localparam int    MEM_WORDS = 1024;
  localparam word_t DATA_BASE = 32'h400; // loads and random stores
  localparam word_t DUMP_BASE = 32'h700; // final register dump
  localparam int    N_RANDOM  = 150;
  localparam int    TIMEOUT   = 10000;

  logic  clk;
  logic  rst;
  word_t paddr;
  logic  psel;
  logic  penable;
  logic  pwrite;
  word_t pwdata;
  word_t prdata;
  logic  pready;
  logic  trap;

  word_t image [MEM_WORDS];   // program and data loaded at each reset
  word_t mem [MEM_WORDS];     // memory seen by the DUT
  word_t exp_mem [MEM_WORDS];
  word_t model_regs [32];

  word_t exp_addr_q [$];      // expected APB transfers in order
  logic  exp_write_q [$];
  word_t exp_wdata_q [$];
  bit    exp_fetch_q [$];

  bit    waits_on;
  int    wait_left;
  int    xfer_count;
  int    run;
  word_t next_fetch;
  word_t hold_addr;
  word_t hold_wdata;
  logic  hold_write;
  bit    cur_fetch;
  word_t cur_addr;
  word_t cur_wdata;
  logic  cur_write;

  rv_core_top dut_i (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .trap    (trap)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd, input opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, FUNCT3_WORD, imm[4:0], OP_STORE};
  endfunction

  // aligned word offset into the random data area for use with rs1 = x0
  function automatic logic [11:0] data_offset();
    return DATA_BASE[11:0] + 12'($urandom_range(191, 0) * 4);
  endfunction

  // RV32I integer semantics for one funct3 group
  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    logic signed [XLEN-1:0] sra;
    word_t y;
    sra = $signed(a) >>> b[4:0];
    case (f3)
      FUNCT3_ADD:  y = alt ? a - b : a + b;
      FUNCT3_SLL:  y = a << b[4:0];
      FUNCT3_SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      FUNCT3_SLTU: y = (a < b) ? 32'd1 : 32'd0;
      FUNCT3_XOR:  y = a ^ b;
      FUNCT3_SR:   y = alt ? word_t'(sra) : a >> b[4:0];
      FUNCT3_OR:   y = a | b;
      default:     y = a & b;
    endcase
    return y;
  endfunction

  task automatic build_image();
    int        pc_w;
    int        kind;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    for (int i = 0; i < MEM_WORDS; i++) image[i] = $urandom;
    pc_w = 0;
    for (int i = 1; i < 32; i++) begin // every register gets a defined value first
      image[pc_w] = enc_i(DATA_BASE[11:0] + 12'(4 * i), '0, FUNCT3_WORD, reg_addr_t'(i), OP_LOAD);
      pc_w++;
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      kind = $urandom_range(99, 0);
      f3   = $urandom_range(7, 0);
      alt  = $urandom_range(1, 0);
      rd   = reg_addr_t'($urandom_range(31, 0)); // x0 included on purpose
      rs1  = reg_addr_t'($urandom_range(31, 0));
      rs2  = reg_addr_t'($urandom_range(31, 0));
      if (kind < 40) begin
        if ((f3 != FUNCT3_ADD) && (f3 != FUNCT3_SR)) alt = 1'b0;
        image[pc_w] = enc_r(alt ? FUNCT7_ALT : FUNCT7_BASE, rs2, rs1, f3, rd);
      end else if (kind < 75) begin
        imm = $urandom_range(4095, 0);
        if (f3 == FUNCT3_SLL) imm[11:5] = FUNCT7_BASE;
        else if (f3 == FUNCT3_SR) imm[11:5] = alt ? FUNCT7_ALT : FUNCT7_BASE;
        image[pc_w] = enc_i(imm, rs1, f3, rd, OP_IMM);
      end else if (kind < 88) begin
        image[pc_w] = enc_i(data_offset(), '0, FUNCT3_WORD, rd, OP_LOAD);
      end else begin
        image[pc_w] = enc_s(data_offset(), rs2, '0);
      end
      pc_w++;
    end
    for (int i = 0; i < 32; i++) begin // dump x0 to x31
      image[pc_w] = enc_s(DUMP_BASE[11:0] + 12'(4 * i), reg_addr_t'(i), '0);
      pc_w++;
    end
    image[pc_w] = {25'($urandom), 7'b1100011}; // branch opcode is not supported
  endtask

  task automatic push_xfer(input word_t addr, input logic write, input word_t wdata,
                           input bit fetch);
    exp_addr_q.push_back(addr);
    exp_write_q.push_back(write);
    exp_wdata_q.push_back(wdata);
    exp_fetch_q.push_back(fetch);
  endtask

  // instruction level model that builds the expected transfers and final memory
  task automatic run_model();
    word_t pc;
    word_t ir;
    word_t y;
    word_t addr;
    word_t imm_i;
    word_t imm_s;
    logic [6:0] op;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       legal;
    exp_mem = image;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    exp_addr_q.delete();
    exp_write_q.delete();
    exp_wdata_q.delete();
    exp_fetch_q.delete();
    pc = RESET_PC;
    for (int step = 0; step < MEM_WORDS; step++) begin
      push_xfer(pc, 1'b0, '0, 1'b1);
      ir    = exp_mem[pc[11:2]];
      op    = ir[6:0];
      f3    = ir[14:12];
      f7    = ir[31:25];
      imm_i = {{20{ir[31]}}, ir[31:20]};
      imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      case (op)
        OP_REG:  legal = (f7 == FUNCT7_BASE) ||
                         ((f7 == FUNCT7_ALT) && ((f3 == FUNCT3_ADD) || (f3 == FUNCT3_SR)));
        OP_IMM:  legal = (f3 == FUNCT3_SLL) ? (f7 == FUNCT7_BASE) :
                         (f3 == FUNCT3_SR) ? ((f7 == FUNCT7_BASE) || (f7 == FUNCT7_ALT)) : 1'b1;
        OP_LOAD, OP_STORE: legal = (f3 == FUNCT3_WORD);
        default: legal = 1'b0;
      endcase
      if (!legal) return; // core halts here
      case (op)
        OP_REG: y = alu_model(f3, f7 == FUNCT7_ALT, model_regs[ir[19:15]], model_regs[ir[24:20]]);
        OP_IMM: y = alu_model(f3, (f3 == FUNCT3_SR) && (f7 == FUNCT7_ALT),
                              model_regs[ir[19:15]], imm_i);
        OP_LOAD: begin
          addr = model_regs[ir[19:15]] + imm_i;
          push_xfer(addr, 1'b0, '0, 1'b0);
          y = exp_mem[addr[11:2]];
        end
        default: begin
          addr = model_regs[ir[19:15]] + imm_s;
          push_xfer(addr, 1'b1, model_regs[ir[24:20]], 1'b0);
          exp_mem[addr[11:2]] = model_regs[ir[24:20]];
        end
      endcase
      if ((op != OP_STORE) && (ir[11:7] != 5'd0)) model_regs[ir[11:7]] = y;
      pc = pc + 32'd4;
    end
    abort_run("reference model never reached the illegal instruction");
  endtask

  // APB memory with random wait states that also checks every transfer
  always @(negedge clk) begin
    if (rst) begin
      pready <= 1'b0;
    end else if (psel && !penable) begin
      if (exp_addr_q.size() == 0) begin
        abort_run($sformatf("run %0d: APB transfer started with none expected", run));
      end else begin
        cur_fetch = exp_fetch_q.pop_front();
        cur_addr  = exp_addr_q.pop_front();
        cur_write = exp_write_q.pop_front();
        cur_wdata = exp_wdata_q.pop_front();
        if (cur_fetch) begin
          check_word($sformatf("run %0d fetch step", run), next_fetch, paddr);
          next_fetch = next_fetch + 32'd4;
        end
        check_word($sformatf("run %0d xfer %0d paddr", run, xfer_count), cur_addr, paddr);
        check_bit($sformatf("run %0d xfer %0d pwrite", run, xfer_count), cur_write, pwrite);
        if (cur_write) begin
          check_word($sformatf("run %0d xfer %0d pwdata", run, xfer_count), cur_wdata, pwdata);
        end
        xfer_count++;
        hold_addr  = paddr;
        hold_write = pwrite;
        hold_wdata = pwdata;
        wait_left  = waits_on ? $urandom_range(3, 0) : 0;
        pready <= 1'b0;
      end
    end else if (psel && penable) begin
      check_word("paddr held in access", hold_addr, paddr);
      check_bit("pwrite held in access", hold_write, pwrite);
      check_word("pwdata held in access", hold_wdata, pwdata);
      if (wait_left == 0) begin
        pready <= 1'b1;
        prdata <= mem[paddr[11:2]];
        if (pwrite) mem[paddr[11:2]] = pwdata;
      end else begin
        pready <= 1'b0;
        wait_left--;
      end
    end else begin
      pready <= 1'b0;
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    rst <= 1'b1;
    mem = image;
    next_fetch = RESET_PC;
    xfer_count = 0;
    repeat (8) @(negedge clk);
    check_bit("psel in reset", 1'b0, psel);
    check_bit("penable in reset", 1'b0, penable);
    check_bit("pwrite in reset", 1'b0, pwrite);
    check_bit("trap in reset", 1'b0, trap);
    rst <= 1'b0;
  endtask

  task automatic wait_for_trap();
    int cycles;
    cycles = 0;
    while (trap !== 1'b1) begin
      if (cycles == TIMEOUT) begin
        abort_run($sformatf("run %0d timed out before the core trapped", run));
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic check_after_trap();
    if (exp_addr_q.size() != 0) begin
      abort_run($sformatf("run %0d trapped with %0d transfers missing", run, exp_addr_q.size()));
    end
    for (int k = 0; k < 20; k++) begin
      @(negedge clk);
      check_bit("trap held until reset", 1'b1, trap);
      check_bit("psel after trap", 1'b0, psel);
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word($sformatf("run %0d mem[0x%03h]", run, i * 4), exp_mem[i], mem[i]);
    end
  endtask

  initial begin
    rst        = 1'b1;
    prdata     = '0;
    pready     = 1'b0;
    waits_on   = 1'b0;
    wait_left  = 0;
    xfer_count = 0;
    next_fetch = RESET_PC;
    void'($urandom(36));
    for (run = 0; run < 3; run++) begin
      if (run != 1) build_image(); // run 1 repeats run 0 with wait states
      waits_on = (run != 0);
      run_model();
      apply_reset();
      wait_for_trap();
      check_after_trap();
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_top import rv_isa_pkg::*, core_cfg_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  output word_t paddr,
  output logic  psel,
  output logic  penable,
  output logic  pwrite,
  output word_t pwdata,
  input  word_t prdata,
  input  logic  pready,
  output logic  trap
);

  mem_req_if mem_if ();

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  logic      rd_we;
  word_t     rd_wdata;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_a;
  word_t     alu_b;
  alu_op_t   alu_op;
  word_t     alu_y;
  imm_fmt_t  imm_fmt;
  word_t     instr;
  word_t     imm;

  core_ctrl ctrl_i (
    .clk      (clk),
    .rst      (rst),
    .mem      (mem_if.ctrl),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_we    (rd_we),
    .rd_wdata (rd_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .alu_a    (alu_a),
    .alu_b    (alu_b),
    .alu_op   (alu_op),
    .alu_y    (alu_y),
    .imm_fmt  (imm_fmt),
    .instr    (instr),
    .imm      (imm),
    .trap     (trap)
  );

  reg_file rf_i (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_we    (rd_we),
    .rd_wdata (rd_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu_i (
    .a  (alu_a),
    .b  (alu_b),
    .op (alu_op),
    .y  (alu_y)
  );

  imm_gen imm_i (
    .instr (instr),
    .fmt   (imm_fmt),
    .imm   (imm)
  );

  apb_requester apb_i (
    .clk     (clk),
    .rst     (rst),
    .mem     (mem_if.bus),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready)
  );

endmodule

`default_nettype wire

/* hdl/core_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module core_ctrl import rv_isa_pkg::*, core_cfg_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  mem_req_if.ctrl   mem,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output reg_addr_t rd_addr,
  output logic      rd_we,
  output word_t     rd_wdata,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output word_t     alu_a,
  output word_t     alu_b,
  output alu_op_t   alu_op,
  input  word_t     alu_y,
  output imm_fmt_t  imm_fmt,
  output word_t     instr,
  input  word_t     imm,
  output logic      trap
);

  ctrl_state_t state;
  word_t       pc;
  word_t       ir;
  word_t       opa;
  word_t       opb;
  word_t       sdata; // rs2 kept for stores
  word_t       res;   // alu result or load data

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        legal;
  logic        is_mem;
  logic        is_store;
  logic        mem_phase;

  function automatic alu_op_t op_from_funct(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      FUNCT3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      FUNCT3_SLL:  op = ALU_SLL;
      FUNCT3_SLT:  op = ALU_SLT;
      FUNCT3_SLTU: op = ALU_SLTU;
      FUNCT3_XOR:  op = ALU_XOR;
      FUNCT3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      FUNCT3_OR:   op = ALU_OR;
      default:     op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode   = opcode_t'(ir[OPCODE_MSB:OPCODE_LSB]);
  assign funct3   = ir[FUNCT3_MSB:FUNCT3_LSB];
  assign funct7   = ir[FUNCT7_MSB:FUNCT7_LSB];
  assign is_store = (opcode == OP_STORE);
  assign is_mem   = (opcode == OP_LOAD) || is_store;

  // decode and legality check, anything not listed ends in TRAP
  always_comb begin
    legal  = 1'b0;
    alu_op = ALU_ADD; // address add for loads and stores
    case (opcode)
      OP_REG: begin
        legal  = (funct7 == FUNCT7_BASE) ||
                 ((funct7 == FUNCT7_ALT) && ((funct3 == FUNCT3_ADD) || (funct3 == FUNCT3_SR)));
        alu_op = op_from_funct(funct3, funct7 == FUNCT7_ALT);
      end
      OP_IMM: begin
        case (funct3)
          FUNCT3_SLL: legal = (funct7 == FUNCT7_BASE);
          FUNCT3_SR:  legal = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
          default:    legal = 1'b1;
        endcase
        // imm[10] only means arithmetic shift for the shift group
        alu_op = op_from_funct(funct3, (funct3 == FUNCT3_SR) && (funct7 == FUNCT7_ALT));
      end
      OP_LOAD, OP_STORE: legal = (funct3 == FUNCT3_WORD);
      default: legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FETCH_REQ;
      pc    <= RESET_PC;
    end else begin
      case (state)
        FETCH_REQ:  state <= FETCH_WAIT;
        FETCH_WAIT: if (mem.done) state <= DECODE;
        DECODE:     state <= legal ? EXECUTE : TRAP;
        EXECUTE:    state <= is_mem ? MEM_REQ : WRITEBACK;
        MEM_REQ:    state <= MEM_WAIT;
        MEM_WAIT: begin
          if (mem.done) begin
            if (is_store) begin
              state <= FETCH_REQ; // store has no writeback
              pc    <= pc + PC_STEP;
            end else begin
              state <= WRITEBACK;
            end
          end
        end
        WRITEBACK: begin
          state <= FETCH_REQ;
          pc    <= pc + PC_STEP;
        end
        default: state <= TRAP; // halted until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      FETCH_WAIT: if (mem.done) ir <= mem.rdata;
      DECODE: begin
        opa   <= rs1_data;
        opb   <= (opcode == OP_REG) ? rs2_data : imm;
        sdata <= rs2_data;
      end
      EXECUTE:  res <= alu_y;
      MEM_WAIT: if (mem.done) res <= mem.rdata; // only kept for loads
      default: ;
    endcase
  end

  assign mem_phase = (state == MEM_REQ) || (state == MEM_WAIT);
  assign mem.req   = (state == FETCH_REQ) || (state == FETCH_WAIT) || mem_phase;
  assign mem.write = mem_phase && is_store;
  assign mem.addr  = mem_phase ? res : pc;
  assign mem.wdata = sdata;

  assign rs1_addr = ir[RS1_MSB:RS1_LSB];
  assign rs2_addr = ir[RS2_MSB:RS2_LSB];
  assign rd_addr  = ir[RD_MSB:RD_LSB];
  assign rd_we    = (state == WRITEBACK);
  assign rd_wdata = res;
  assign alu_a    = opa;
  assign alu_b    = opb;
  assign imm_fmt  = is_store ? IMM_S : IMM_I;
  assign instr    = ir;
  assign trap     = (state == TRAP);

  // a new request may only start once the previous done has passed
  a_req_after_done: assert property (
    @(posedge clk) disable iff (rst) $rose(mem.req) |-> !mem.done
  ) else $error("req rose while done was high");

endmodule

`default_nettype wire

/* hdl/apb_requester.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_requester import core_cfg_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  mem_req_if.bus mem,
  output word_t paddr,
  output logic  psel,
  output logic  penable,
  output logic  pwrite,
  output word_t pwdata,
  input  word_t prdata,
  input  logic  pready
);

  typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_t;

  apb_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= APB_IDLE;
      pwrite <= 1'b0;
    end else begin
      case (state)
        APB_IDLE: begin
          if (mem.req) begin
            state  <= APB_SETUP;
            pwrite <= mem.write;
          end
        end
        APB_SETUP:  state <= APB_ACCESS;
        APB_ACCESS: if (pready) state <= APB_IDLE; // wait states hold here
        default:    state <= APB_IDLE;
      endcase
    end
  end

  // address and data captured once, held through setup and access
  always_ff @(posedge clk) begin
    if ((state == APB_IDLE) && mem.req) begin
      paddr  <= mem.addr;
      pwdata <= mem.wdata;
    end
  end

  assign psel      = (state != APB_IDLE);
  assign penable   = (state == APB_ACCESS);
  assign mem.done  = penable && pready;
  assign mem.rdata = prdata;

  a_penable_psel: assert property (
    @(posedge clk) disable iff (rst) penable |-> psel
  ) else $error("penable without psel");

  a_stable_wait: assert property (
    @(posedge clk) disable iff (rst)
    (penable && !pready) |=> ($stable(paddr) && $stable(pwdata))
  ) else $error("paddr or pwdata changed during a wait state");

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file import core_cfg_pkg::*; (
  input  logic      clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  input  logic      rd_we,
  input  word_t     rd_wdata,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  // entry 0 is never written, reads of x0 are forced to zero below
  word_t regs [0:2**REG_ADDR_W-1];

  always_ff @(posedge clk) begin
    if (rd_we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr]; // async read
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* hdl/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module imm_gen import rv_isa_pkg::*, core_cfg_pkg::*; (
  input  word_t    instr,
  input  imm_fmt_t fmt,
  output word_t    imm
);

  logic [IMM_W-1:0] raw;

  // S format splits the immediate around rd
  always_comb begin
    case (fmt)
      IMM_S:   raw = {instr[IMM_S_HI_MSB:IMM_S_HI_LSB], instr[IMM_S_LO_MSB:IMM_S_LO_LSB]};
      default: raw = instr[IMM_I_MSB:IMM_I_LSB];
    endcase
  end

  assign imm = {{(XLEN-IMM_W){raw[IMM_W-1]}}, raw}; // sign extend

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu import rv_isa_pkg::*, core_cfg_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   y
);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt       = b[SHAMT_W-1:0]; // only the low bits count
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_SLL:  y = a << shamt;
      ALU_SLT:  y = word_t'(lt_signed);
      ALU_SLTU: y = word_t'(lt_unsigned);
      ALU_XOR:  y = a ^ b;
      ALU_SRL:  y = a >> shamt;
      ALU_SRA:  y = word_t'($signed(a) >>> shamt); // keeps the sign bit
      ALU_OR:   y = a | b;
      ALU_AND:  y = a & b;
      default:  y = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/mem_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if import core_cfg_pkg::*; ();

  logic  req;   // held until done
  logic  write;
  word_t addr;
  word_t wdata;
  logic  done;  // one cycle per request
  word_t rdata; // valid with done

  modport ctrl (
    output req, write, addr, wdata,
    input  done, rdata
  );

  modport bus (
    input  req, write, addr, wdata,
    output done, rdata
  );

endinterface

`default_nettype wire

/* hdl/core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = $clog2(XLEN); // shift amount bits taken from b

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  localparam word_t RESET_PC = '0;
  localparam word_t PC_STEP  = 32'd4; // no compressed or jump targets

  // multicycle controller states
  typedef enum logic [2:0] {
    FETCH_REQ,
    FETCH_WAIT,
    DECODE,
    EXECUTE,
    MEM_REQ,
    MEM_WAIT,
    WRITEBACK,
    TRAP
  } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // major opcodes of the supported instruction groups
  typedef enum logic [6:0] {
    OP_REG   = 7'b0110011,
    OP_IMM   = 7'b0010011,
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  localparam logic [2:0] FUNCT3_ADD  = 3'b000; // add, sub, addi
  localparam logic [2:0] FUNCT3_SLL  = 3'b001;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU = 3'b011;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_SR   = 3'b101; // srl, sra and immediate forms
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_WORD = 3'b010; // lw, sw

  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // selects sub and sra

  // instruction field positions
  localparam int OPCODE_LSB   = 0;
  localparam int OPCODE_MSB   = 6;
  localparam int RD_LSB       = 7;
  localparam int RD_MSB       = 11;
  localparam int FUNCT3_LSB   = 12;
  localparam int FUNCT3_MSB   = 14;
  localparam int RS1_LSB      = 15;
  localparam int RS1_MSB      = 19;
  localparam int RS2_LSB      = 20;
  localparam int RS2_MSB      = 24;
  localparam int FUNCT7_LSB   = 25;
  localparam int FUNCT7_MSB   = 31;
  localparam int IMM_I_LSB    = 20;
  localparam int IMM_I_MSB    = 31;
  localparam int IMM_S_LO_LSB = 7;
  localparam int IMM_S_LO_MSB = 11;
  localparam int IMM_S_HI_LSB = 25;
  localparam int IMM_S_HI_MSB = 31;
  localparam int IMM_W        = 12; // both kept formats carry 12 bits

  typedef enum logic {IMM_I, IMM_S} imm_fmt_t;

endpackage

`default_nettype wire
